//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_chip_io
FILELIST  := sources.f
OBJ_DIR   := obj_dir
PASS_MSG  := All tests passed!

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run $(TOP) and check the result"
	@echo "  clean  remove the build directory"

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- design/chip_io_padring.sv
////////////////////////////////////////
// Pad ring with per-pad drive variant,
// inversion and MIO input synchronizers
////////////////////////////////////////

`timescale 1ns/100ps

module chip_io_padring
  import chip_io_pkg::*;
(
  // Clock and reset
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  // Requests from the overlay mux
  input  logic [NumIos-1:0]              pad_out_req_i,
  input  logic [NumIos-1:0]              pad_oe_req_i,
  input  logic [NumIos-1:0][AttrDw-1:0]  attr_i,
  // Pad side
  input  logic [NumMio-1:0]              mio_in_i,
  input  logic [NumDio-1:0]              dio_in_i,
  output logic [NumMio-1:0]              mio_out_o,
  output logic [NumMio-1:0]              mio_oe_o,
  output logic [NumDio-1:0]              dio_out_o,
  output logic [NumDio-1:0]              dio_oe_o,
  // Inputs back toward the core
  output logic [NumIos-1:0]              pad_in_raw_o,
  output logic [NumIos-1:0]              pad_in_sync_o
);

  ////////////////////////////////////////
  // Pad cells
  ////////////////////////////////////////

  logic [NumIos-1:0][1:0]    pad_variant;         // Cell type per index
  logic [NumIos-1:0]         pad_in;              // Raw pad levels
  logic [NumIos-1:0]         pad_out;             // Driven pad values
  logic [NumIos-1:0]         pad_oe;              // Driven pad enables
  logic [NumIos-1:0]         pad_od;              // Pad acts as open drain

  assign pad_variant = {DioPadVariant, MioPadVariant}; // DIO above MIO
  assign pad_in      = {dio_in_i, mio_in_i};

  for (genvar k = 0; k < NumIos; k++) begin : g_pad
    logic out_inv;                                // Request after inversion

    assign out_inv = pad_out_req_i[k] ^ attr_i[k][AttrInvertBit];

    // Physical open drain, or bidir forced by attribute
    assign pad_od[k] = (pad_variant[k] == PadOpenDrain) | attr_i[k][AttrOdBit];

    // Open drain only pulls low, enable carries the data
    assign pad_out[k] = pad_od[k] ? 1'b0 : out_inv;
    assign pad_oe[k]  = pad_od[k] ? (pad_oe_req_i[k] & ~out_inv) : pad_oe_req_i[k];

    assign pad_in_raw_o[k] = pad_in[k] ^ attr_i[k][AttrInvertBit]; // Input inversion
  end : g_pad

  // Split back into banks
  assign mio_out_o = pad_out[NumMio-1:0];
  assign mio_oe_o  = pad_oe[NumMio-1:0];
  assign dio_out_o = pad_out[NumIos-1:NumMio];
  assign dio_oe_o  = pad_oe[NumIos-1:NumMio];

  ////////////////////////////////////////
  // MIO input synchronizers
  ////////////////////////////////////////

  logic [SyncStages-1:0][NumMio-1:0] mio_sync_q;  // Stage 0 samples the pad

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      mio_sync_q <= '0;                           // Strap reads low after reset
    end else begin
      mio_sync_q[0] <= pad_in_raw_o[NumMio-1:0];
      for (int s = 1; s < SyncStages; s++) begin
        mio_sync_q[s] <= mio_sync_q[s-1];         // Shift toward the core
      end
    end
  end

  // DIO inputs bypass the flops
  assign pad_in_sync_o = {pad_in_raw_o[NumIos-1:NumMio], mio_sync_q[SyncStages-1]};

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  // Cells built as open drain in the variant table never drive high
  for (genvar k = 0; k < NumMio; k++) begin : g_od_chk
    if (MioPadVariant[k] == PadOpenDrain) begin : g_od
      od_never_high_a: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        !(mio_oe_o[k] && mio_out_o[k])
      ) else $error("Open-drain pad driving high");
    end : g_od
  end : g_od_chk

endmodule : chip_io_padring

//--- design/chip_io_pkg.sv
////////////////////////////////////////
// Pad counts, attribute bits, pad variant
// table and JTAG pin map of the chip I/O
////////////////////////////////////////

package chip_io_pkg;

  ////////////////////////////////////////
  // Pad counts
  ////////////////////////////////////////

  localparam int NumMio = 16;                     // Multiplexed pads
  localparam int NumDio = 6;                      // Dedicated pads
  localparam int NumIos = NumMio + NumDio;        // MIO low, DIO above

  ////////////////////////////////////////
  // Pad attributes
  ////////////////////////////////////////

  localparam int AttrDw        = 2;               // Attribute bits per pad
  localparam int AttrInvertBit = 0;               // Invert out and in
  localparam int AttrOdBit     = 1;               // Virtual open drain

  // Pad cell variant codes
  localparam logic [1:0] PadBidir     = 2'd0;     // Push-pull bidir
  localparam logic [1:0] PadOpenDrain = 2'd3;     // Pull-down only

  // MIO cell types, MIO 15 first
  localparam logic [NumMio-1:0][1:0] MioPadVariant = {
    PadBidir,                                     // MIO 15
    PadBidir,                                     // MIO 14
    PadBidir,                                     // MIO 13
    PadBidir,                                     // MIO 12, JTAG strap
    PadBidir,                                     // MIO 11
    PadBidir,                                     // MIO 10, SRST
    PadBidir,                                     // MIO 9, TRST
    PadBidir,                                     // MIO 8
    PadOpenDrain,                                 // MIO 7
    PadOpenDrain,                                 // MIO 6
    PadBidir,                                     // MIO 5
    PadBidir,                                     // MIO 4
    PadBidir,                                     // MIO 3
    PadBidir,                                     // MIO 2
    PadOpenDrain,                                 // MIO 1
    PadOpenDrain                                  // MIO 0
  };

  // DIO cells are all plain bidir
  localparam logic [NumDio-1:0][1:0] DioPadVariant = {NumDio{PadBidir}};

  ////////////////////////////////////////
  // Input synchronizer
  ////////////////////////////////////////

  localparam int SyncStages = 2;                  // Flops per MIO input

  ////////////////////////////////////////
  // JTAG overlay
  ////////////////////////////////////////

  // All indices below point into the full core-side vector
  localparam int   JtagEnIdx      = 12;           // Strap on MIO 12
  localparam logic JtagEnPolarity = 1'b1;         // High strap selects JTAG
  localparam int   TrstIdx        = 9;            // MIO 9
  localparam int   SrstIdx        = 10;           // MIO 10
  localparam int   TdiIdx         = NumMio + 0;   // DIO 0
  localparam int   TdoIdx         = NumMio + 1;   // DIO 1
  localparam int   TmsIdx         = NumMio + 4;   // DIO 4, chip select
  localparam int   TckIdx         = NumMio + 5;   // DIO 5, serial clock

  // Core sees an inactive chip select while the pins are borrowed
  localparam logic [NumIos-1:0] TieOffValues =
    {{(NumIos-1){1'b0}}, 1'b1} << TmsIdx;

endpackage : chip_io_pkg

//--- design/chip_io_top.sv
////////////////////////////////////////
// Chip I/O top, pad ring plus JTAG mux
////////////////////////////////////////

`timescale 1ns/100ps

module chip_io_top
  import chip_io_pkg::*;
(
  // Clock and reset
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  // Core side
  input  logic [NumIos-1:0]              core_out_i,
  input  logic [NumIos-1:0]              core_oe_i,
  input  logic [NumIos-1:0][AttrDw-1:0]  core_attr_i,
  output logic [NumIos-1:0]              core_in_o,
  // JTAG toward the core
  output logic                           jtag_tck_o,
  output logic                           jtag_tms_o,
  output logic                           jtag_tdi_o,
  output logic                           jtag_trst_n_o,
  output logic                           jtag_srst_n_o,
  input  logic                           jtag_tdo_i,
  // Pads
  input  logic [NumMio-1:0]              mio_in_i,
  input  logic [NumDio-1:0]              dio_in_i,
  output logic [NumMio-1:0]              mio_out_o,
  output logic [NumMio-1:0]              mio_oe_o,
  output logic [NumDio-1:0]              dio_out_o,
  output logic [NumDio-1:0]              dio_oe_o
);

  ////////////////////////////////////////
  // Mux to pad ring wires
  ////////////////////////////////////////

  logic [NumIos-1:0] pad_out_req;                 // Values after overlay
  logic [NumIos-1:0] pad_oe_req;                  // Enables after overlay
  logic [NumIos-1:0] pad_in_raw;                  // Unsynchronized inputs
  logic [NumIos-1:0] pad_in_sync;                 // MIO synchronized

  ////////////////////////////////////////
  // Pad ring
  ////////////////////////////////////////

  chip_io_padring chip_io_padring (
    .clk_i         ( clk_i       ),
    .rst_n_i       ( rst_n_i     ),
    .pad_out_req_i ( pad_out_req ),
    .pad_oe_req_i  ( pad_oe_req  ),
    .attr_i        ( core_attr_i ),               // Straight from the core
    .mio_in_i      ( mio_in_i    ),
    .dio_in_i      ( dio_in_i    ),
    .mio_out_o     ( mio_out_o   ),
    .mio_oe_o      ( mio_oe_o    ),
    .dio_out_o     ( dio_out_o   ),
    .dio_oe_o      ( dio_oe_o    ),
    .pad_in_raw_o  ( pad_in_raw  ),
    .pad_in_sync_o ( pad_in_sync )
  );

  ////////////////////////////////////////
  // JTAG overlay
  ////////////////////////////////////////

  jtag_overlay_mux jtag_overlay_mux (
    // Core side
    .core_out_i    ( core_out_i    ),
    .core_oe_i     ( core_oe_i     ),
    .core_in_o     ( core_in_o     ),
    // Pad ring side
    .pad_out_req_o ( pad_out_req   ),
    .pad_oe_req_o  ( pad_oe_req    ),
    .pad_in_raw_i  ( pad_in_raw    ),             // TAP pins skip the sync
    .pad_in_sync_i ( pad_in_sync   ),             // Strap and core inputs
    // TAP
    .jtag_tdo_i    ( jtag_tdo_i    ),
    .jtag_tck_o    ( jtag_tck_o    ),
    .jtag_tms_o    ( jtag_tms_o    ),
    .jtag_tdi_o    ( jtag_tdi_o    ),
    .jtag_trst_n_o ( jtag_trst_n_o ),
    .jtag_srst_n_o ( jtag_srst_n_o )
  );

endmodule : chip_io_top

//--- design/jtag_overlay_mux.sv
////////////////////////////////////////
// JTAG overlay mux, borrows six pads
// while the strap is set
////////////////////////////////////////

`timescale 1ns/100ps

module jtag_overlay_mux
  import chip_io_pkg::*;
(
  // Core side
  input  logic [NumIos-1:0] core_out_i,
  input  logic [NumIos-1:0] core_oe_i,
  output logic [NumIos-1:0] core_in_o,
  // Pad ring side
  output logic [NumIos-1:0] pad_out_req_o,
  output logic [NumIos-1:0] pad_oe_req_o,
  input  logic [NumIos-1:0] pad_in_raw_i,
  input  logic [NumIos-1:0] pad_in_sync_i,
  // JTAG toward the core
  input  logic              jtag_tdo_i,
  output logic              jtag_tck_o,
  output logic              jtag_tms_o,
  output logic              jtag_tdi_o,
  output logic              jtag_trst_n_o,
  output logic              jtag_srst_n_o
);

  ////////////////////////////////////////
  // Strap and borrowed pins
  ////////////////////////////////////////

  logic              jtag_en;                     // Overlay active
  logic [NumIos-1:0] jtag_pins;                   // Borrowed positions
  logic [NumIos-1:0] jtag_in_pins;                // Borrowed, pad-to-core

  // Synchronized strap, so mode changes line up with MIO inputs
  assign jtag_en = (pad_in_sync_i[JtagEnIdx] == JtagEnPolarity);

  always_comb begin
    jtag_in_pins          = '0;
    jtag_in_pins[TckIdx]  = 1'b1;
    jtag_in_pins[TmsIdx]  = 1'b1;
    jtag_in_pins[TdiIdx]  = 1'b1;
    jtag_in_pins[TrstIdx] = 1'b1;
    jtag_in_pins[SrstIdx] = 1'b1;
  end

  always_comb begin
    jtag_pins         = jtag_in_pins;
    jtag_pins[TdoIdx] = 1'b1;                     // TDO is the only driver
  end

  ////////////////////////////////////////
  // Pad steering
  ////////////////////////////////////////

  always_comb begin
    pad_out_req_o = core_out_i;                   // Default pass-through
    pad_oe_req_o  = core_oe_i;
    if (jtag_en) begin
      pad_oe_req_o          = core_oe_i & ~jtag_in_pins; // Inputs stay quiet
      pad_out_req_o[TdoIdx] = jtag_tdo_i;
      pad_oe_req_o[TdoIdx]  = 1'b1;
    end
  end

  // Core sees fixed levels on borrowed pins
  always_comb begin
    core_in_o = pad_in_sync_i;
    if (jtag_en) begin
      core_in_o = (pad_in_sync_i & ~jtag_pins) | (TieOffValues & jtag_pins);
    end
  end

  ////////////////////////////////////////
  // JTAG port
  ////////////////////////////////////////

  // Raw pad levels, TAP runs on its own clock
  always_comb begin
    jtag_tck_o    = 1'b0;                         // Idle TAP
    jtag_tms_o    = 1'b1;
    jtag_tdi_o    = 1'b0;
    jtag_trst_n_o = 1'b0;                         // Held in reset
    jtag_srst_n_o = 1'b0;
    if (jtag_en) begin
      jtag_tck_o    = pad_in_raw_i[TckIdx];
      jtag_tms_o    = pad_in_raw_i[TmsIdx];
      jtag_tdi_o    = pad_in_raw_i[TdiIdx];
      jtag_trst_n_o = pad_in_raw_i[TrstIdx];
      jtag_srst_n_o = pad_in_raw_i[SrstIdx];
    end
  end

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  // Strap from the pad ring must hand TDO to the TAP and release TCK
  always_comb begin
    if (pad_in_sync_i[JtagEnIdx] == JtagEnPolarity) begin
      tdo_owned_a: assert (pad_oe_req_o[TdoIdx] && !pad_oe_req_o[TckIdx])
        else $error("JTAG active but TDO/TCK enables wrong");
    end
  end

endmodule : jtag_overlay_mux

//--- sources.f
design/chip_io_pkg.sv
design/chip_io_padring.sv
design/jtag_overlay_mux.sv
design/chip_io_top.sv
verif/tb_clk_gen.sv
verif/tb_chip_io.sv

//--- verif/tb_chip_io.sv
////////////////////////////////////////
// Chip I/O testbench, directed tests of
// pad drive, input sync and JTAG overlay
////////////////////////////////////////

`timescale 1ns/100ps

module tb_chip_io
  import chip_io_pkg::*;
();

  localparam int NumTests   = 5;
  localparam int WatchdogNs = NumTests * 200 * 10; // 200 cycles per test

  logic                          clk;
  logic                          rst_n;
  logic [NumIos-1:0]             core_out;
  logic [NumIos-1:0]             core_oe;
  logic [NumIos-1:0][AttrDw-1:0] core_attr;
  logic [NumIos-1:0]             core_in;
  logic                          jtag_tck;
  logic                          jtag_tms;
  logic                          jtag_tdi;
  logic                          jtag_trst_n;
  logic                          jtag_srst_n;
  logic                          jtag_tdo;
  logic [NumMio-1:0]             mio_in;
  logic [NumMio-1:0]             mio_out;
  logic [NumMio-1:0]             mio_oe;
  logic [NumDio-1:0]             dio_in;
  logic [NumDio-1:0]             dio_out;
  logic [NumDio-1:0]             dio_oe;

  int errors;                                     // Mismatches so far
  int checks;                                     // Compares so far
  int tests_run;

  tb_clk_gen #(.PeriodNs(10)) clk_gen_i (.clk_o(clk));

  chip_io_top dut_i (
    .clk_i         ( clk         ),
    .rst_n_i       ( rst_n       ),
    .core_out_i    ( core_out    ),
    .core_oe_i     ( core_oe     ),
    .core_attr_i   ( core_attr   ),
    .core_in_o     ( core_in     ),
    .jtag_tck_o    ( jtag_tck    ),
    .jtag_tms_o    ( jtag_tms    ),
    .jtag_tdi_o    ( jtag_tdi    ),
    .jtag_trst_n_o ( jtag_trst_n ),
    .jtag_srst_n_o ( jtag_srst_n ),
    .jtag_tdo_i    ( jtag_tdo    ),
    .mio_in_i      ( mio_in      ),
    .dio_in_i      ( dio_in      ),
    .mio_out_o     ( mio_out     ),
    .mio_oe_o      ( mio_oe      ),
    .dio_out_o     ( dio_out     ),
    .dio_oe_o      ( dio_oe      )
  );

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp_val);
    checks++;
    if (got !== exp_val) begin
      errors++;
      $display("FAIL %0d ns: %s, got 0x%0h, expected 0x%0h", $time, what, got, exp_val);
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;                                           // Drive point after the edge
  endtask

  task automatic settle();
    #1;                                           // Combinational paths done
  endtask

  // MIO 0, 1, 6, 7 are open-drain cells
  function automatic logic od_cell(input int k);
    return (k == 0) || (k == 1) || (k == 6) || (k == 7);
  endfunction

  function automatic logic [NumIos-1:0] invert_bits(
    input logic [NumIos-1:0][AttrDw-1:0] attr
  );
    logic [NumIos-1:0] inv;
    for (int k = 0; k < NumIos; k++) begin
      inv[k] = attr[k][AttrInvertBit];
    end
    return inv;
  endfunction

  function automatic logic [NumIos-1:0] borrowed_mask();
    logic [NumIos-1:0] m;
    m          = '0;
    m[TckIdx]  = 1'b1;
    m[TmsIdx]  = 1'b1;
    m[TdiIdx]  = 1'b1;
    m[TdoIdx]  = 1'b1;
    m[TrstIdx] = 1'b1;
    m[SrstIdx] = 1'b1;
    return m;
  endfunction

  function automatic logic [NumIos-1:0] tie_off_value();
    logic [NumIos-1:0] v;
    v         = '0;
    v[TmsIdx] = 1'b1;                             // Chip select held inactive
    return v;
  endfunction

  // Core view once MIO inputs have been stable for two edges
  function automatic logic [NumIos-1:0] settled_core_in();
    return {dio_in, mio_in} ^ invert_bits(core_attr);
  endfunction

  // Expected pad outputs for a request, bidir or open-drain rule
  task automatic model_pads(input logic [NumIos-1:0] req_out, input logic [NumIos-1:0] req_oe,
                            input logic [NumIos-1:0][AttrDw-1:0] attr,
                            output logic [NumIos-1:0] exp_out,
                            output logic [NumIos-1:0] exp_oe);
    logic val;
    for (int k = 0; k < NumIos; k++) begin
      val = req_out[k] ^ attr[k][AttrInvertBit];
      if (od_cell(k) || attr[k][AttrOdBit]) begin
        exp_out[k] = 1'b0;                        // Only pulls low
        exp_oe[k]  = req_oe[k] & ~val;
      end else begin
        exp_out[k] = val;
        exp_oe[k]  = req_oe[k];
      end
    end
  endtask

  task automatic compare_pads(input string tag, input logic [NumIos-1:0] req_out,
                              input logic [NumIos-1:0] req_oe);
    logic [NumIos-1:0] exp_out;
    logic [NumIos-1:0] exp_oe;
    model_pads(req_out, req_oe, core_attr, exp_out, exp_oe);
    check_value({tag, " pad out"}, 32'({dio_out, mio_out}), 32'(exp_out));
    check_value({tag, " pad oe"}, 32'({dio_oe, mio_oe}), 32'(exp_oe));
  endtask

  task automatic compare_core_in(input string tag, input logic jtag_on);
    logic [NumIos-1:0] exp_in;
    exp_in = settled_core_in();
    if (jtag_on) begin
      exp_in = (exp_in & ~borrowed_mask()) | (tie_off_value() & borrowed_mask());
    end
    check_value({tag, " core_in"}, 32'(core_in), 32'(exp_in));
  endtask

  task automatic verify_jtag_idle(input string tag);
    check_value({tag, " tck idle"}, 32'(jtag_tck), 32'd0);
    check_value({tag, " tms idle"}, 32'(jtag_tms), 32'd1);
    check_value({tag, " tdi idle"}, 32'(jtag_tdi), 32'd0);
    check_value({tag, " trst_n idle"}, 32'(jtag_trst_n), 32'd0);
    check_value({tag, " srst_n idle"}, 32'(jtag_srst_n), 32'd0);
  endtask

  task automatic verify_jtag_active(input string tag);
    logic [NumIos-1:0] raw;
    logic [NumIos-1:0] req_out;
    logic [NumIos-1:0] req_oe;
    raw = {dio_in, mio_in} ^ invert_bits(core_attr); // TAP pins skip the sync
    check_value({tag, " tck"}, 32'(jtag_tck), 32'(raw[TckIdx]));
    check_value({tag, " tms"}, 32'(jtag_tms), 32'(raw[TmsIdx]));
    check_value({tag, " tdi"}, 32'(jtag_tdi), 32'(raw[TdiIdx]));
    check_value({tag, " trst_n"}, 32'(jtag_trst_n), 32'(raw[TrstIdx]));
    check_value({tag, " srst_n"}, 32'(jtag_srst_n), 32'(raw[SrstIdx]));
    req_out         = core_out;
    req_out[TdoIdx] = jtag_tdo;
    req_oe          = core_oe & ~borrowed_mask(); // Borrowed inputs released
    req_oe[TdoIdx]  = 1'b1;
    compare_pads(tag, req_out, req_oe);
    check_value({tag, " tdo pad"}, 32'(dio_out[TdoIdx-NumMio]), 32'(jtag_tdo));
    check_value({tag, " tdo enable"}, 32'(dio_oe[TdoIdx-NumMio]), 32'd1);
  endtask

  task automatic random_core_drive();
    logic [31:0] r;
    r        = $urandom();
    core_out = r[NumIos-1:0];
    r        = $urandom();
    core_oe  = r[NumIos-1:0];
  endtask

  // Random attributes, cleared where the mask is set
  task automatic pick_attrs(input logic [NumIos-1:0] clear_mask);
    logic [31:0] r;
    for (int k = 0; k < NumIos; k++) begin
      r            = $urandom();
      core_attr[k] = clear_mask[k] ? '0 : r[AttrDw-1:0];
    end
    core_attr[JtagEnIdx][AttrInvertBit] = 1'b0;  // Strap reads as driven
  endtask

  task automatic new_pad_levels(input logic strap);
    logic [31:0] r;
    r                 = $urandom();
    mio_in            = r[NumMio-1:0];
    mio_in[JtagEnIdx] = strap;
    r                 = $urandom();
    dio_in            = r[NumDio-1:0];
  endtask

  task automatic end_test(input string name, input int errs_at_start);
    tests_run++;
    $display("[%0d ns] %s done, %0d mismatches", $time, name, errors - errs_at_start);
  endtask

  ////////////////////////////////////////
  // Tests
  ////////////////////////////////////////

  task automatic reset_state();
    int errs_at_start;
    logic [31:0] r;
    errs_at_start = errors;
    r       = $urandom();
    core_oe = r[NumIos-1:0];                      // Outputs low, cells follow oe
    settle();
    verify_jtag_idle("reset");
    check_value("reset pad oe", 32'({dio_oe, mio_oe}), 32'(core_oe));
    check_value("reset core_in", 32'(core_in), 32'd0);
    end_test("reset_state", errs_at_start);
  endtask

  task automatic output_drive();
    int errs_at_start;
    errs_at_start = errors;
    for (int i = 0; i < 16; i++) begin
      next_cycle();
      random_core_drive();
      pick_attrs('0);
      settle();
      compare_pads($sformatf("drive %0d", i), core_out, core_oe);
    end
    next_cycle();
    for (int k = 0; k < NumIos; k++) begin
      core_attr[k]            = '0;
      core_attr[k][AttrOdBit] = 1'b1;            // Every cell open drain
    end
    core_out = '0;
    core_oe  = '1;
    settle();
    check_value("od pull low out", 32'({dio_out, mio_out}), 32'd0);
    check_value("od pull low oe", 32'({dio_oe, mio_oe}), 32'(core_oe));
    next_cycle();
    core_out = '1;                                // High request leaves pads floating
    settle();
    check_value("od release oe", 32'({dio_oe, mio_oe}), 32'd0);
    end_test("output_drive", errs_at_start);
  endtask

  task automatic input_path();
    int errs_at_start;
    logic [NumIos-1:0] old_in;
    logic [NumIos-1:0] new_in;
    logic [31:0] r;
    errs_at_start = errors;
    next_cycle();
    pick_attrs('0);
    new_pad_levels(1'b0);
    repeat (3) next_cycle();
    settle();
    old_in = settled_core_in();
    check_value("input settled", 32'(core_in), 32'(old_in));
    next_cycle();
    mio_in            = ~mio_in;                  // Every MIO bit moves
    mio_in[JtagEnIdx] = 1'b0;
    r                 = $urandom();
    dio_in            = r[NumDio-1:0];
    settle();
    new_in = settled_core_in();
    check_value("dio same cycle", 32'(core_in[NumIos-1:NumMio]), 32'(new_in[NumIos-1:NumMio]));
    check_value("mio before edge", 32'(core_in[NumMio-1:0]), 32'(old_in[NumMio-1:0]));
    next_cycle();
    settle();
    check_value("mio after 1 edge", 32'(core_in[NumMio-1:0]), 32'(old_in[NumMio-1:0]));
    next_cycle();
    settle();
    check_value("mio after 2 edges", 32'(core_in[NumMio-1:0]), 32'(new_in[NumMio-1:0]));
    end_test("input_path", errs_at_start);
  endtask

  task automatic jtag_takeover();
    int errs_at_start;
    logic [31:0] r;
    errs_at_start = errors;
    next_cycle();
    pick_attrs(borrowed_mask());                  // Plain cells on TAP pins
    random_core_drive();
    core_oe[TdoIdx] = 1'b0;                       // Overlay must raise it
    core_oe[TckIdx] = 1'b1;                       // Overlay must drop it
    new_pad_levels(1'b1);
    r        = $urandom();
    jtag_tdo = r[0];
    next_cycle();
    settle();
    check_value("strap 1 edge tdo oe", 32'(dio_oe[TdoIdx-NumMio]), 32'd0);
    check_value("strap 1 edge trst_n", 32'(jtag_trst_n), 32'd0);
    next_cycle();
    settle();
    verify_jtag_active("takeover");
    compare_core_in("takeover", 1'b1);
    for (int i = 0; i < 4; i++) begin
      next_cycle();
      random_core_drive();
      new_pad_levels(1'b1);
      r        = $urandom();
      jtag_tdo = r[0];
      settle();
      verify_jtag_active($sformatf("jtag %0d", i)); // Raw path, no delay
      repeat (2) next_cycle();
      settle();
      compare_core_in($sformatf("jtag %0d", i), 1'b1);
    end
    end_test("jtag_takeover", errs_at_start);
  endtask

  task automatic jtag_release();
    int errs_at_start;
    errs_at_start = errors;
    next_cycle();
    core_oe[TdoIdx]   = 1'b0;
    core_oe[TckIdx]   = 1'b1;
    mio_in[JtagEnIdx] = 1'b0;                     // Strap cleared
    next_cycle();
    settle();
    check_value("release 1 edge tdo oe", 32'(dio_oe[TdoIdx-NumMio]), 32'd1);
    next_cycle();
    settle();
    verify_jtag_idle("release");
    compare_pads("release", core_out, core_oe);
    compare_core_in("release", 1'b0);
    end_test("jtag_release", errs_at_start);
  endtask

  ////////////////////////////////////////
  // Main sequence and watchdog
  ////////////////////////////////////////

  initial begin
    void'($urandom(95355));
    errors    = 0;
    checks    = 0;
    tests_run = 0;
    rst_n     = 1'b0;
    core_out  = '0;
    core_oe   = '0;
    core_attr = '0;
    mio_in    = '0;
    dio_in    = '0;
    jtag_tdo  = 1'b0;
    repeat (5) @(posedge clk);                    // Reset for 5 cycles
    #1;
    rst_n = 1'b1;
    reset_state();
    output_drive();
    input_path();
    jtag_takeover();
    jtag_release();
    $display("Summary: %0d tests, %0d checks, %0d errors", tests_run, checks, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  initial begin
    #(WatchdogNs);
    $display("Watchdog expired after %0d ns, the tests did not complete", WatchdogNs);
    $display("Test failures found");
    $finish;
  end

endmodule : tb_chip_io

//--- verif/tb_clk_gen.sv
////////////////////////////////////////
// Testbench clock source
////////////////////////////////////////

`timescale 1ns/100ps

module tb_clk_gen #(
  parameter int PeriodNs = 10                     // Full clock period
) (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;                                 // Known level at time 0
  end

  always begin
    #(PeriodNs / 2);
    clk_o = ~clk_o;                               // Half period toggle
  end

endmodule : tb_clk_gen
